// ==== build.f ====
+incdir+bench
hw/srcPkg.sv
hw/stageIf.sv
hw/regBank.sv
hw/instrDecode.sv
hw/aluExecute.sv
hw/resultStage.sv
hw/srcCore.sv
bench/srcCoreTb.sv

// ==== Bender.yml ====
package:
  name: src_core

sources:
  - hw/srcPkg.sv
  - hw/stageIf.sv
  - hw/regBank.sv
  - hw/instrDecode.sv
  - hw/aluExecute.sv
  - hw/resultStage.sv
  - hw/srcCore.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/srcCoreTb.sv

// ==== bench/srcCoreRef.svh ====
`ifndef SRC_CORE_REF_SVH
`define SRC_CORE_REF_SVH

// Register mirror, cleared with the DUT reset
logic [srcPkg::InstrWidth-1:0] mirror [srcPkg::RegCount];

// Expected outcome of one instruction, from the instruction set rules
function automatic srcPkg::ExecResult refExecute(input logic [srcPkg::InstrWidth-1:0] word);
    srcPkg::ExecResult               res;
    logic [srcPkg::InstrWidth-1:0]   srcB, srcC, tested, imm;
    logic [2*srcPkg::InstrWidth-1:0] pair;  // Doubled word for rotates
    logic [4:0]                      amount;
    res     = '0;
    res.destReg = word[26:23];  // Ra
    res.writes  = 1'b1;
    srcB    = mirror[word[22:19]];
    srcC    = mirror[word[18:15]];
    tested  = mirror[word[26:23]];  // Branch tests Ra
    imm     = {{(srcPkg::InstrWidth - srcPkg::ImmWidth){word[18]}}, word[18:0]};
    amount  = srcC[4:0];
    case (word[31:27])
        srcPkg::OpAdd:  res.value = srcB + srcC;
        srcPkg::OpSub:  res.value = srcB - srcC;
        srcPkg::OpAnd:  res.value = srcB & srcC;
        srcPkg::OpOr:   res.value = srcB | srcC;
        srcPkg::OpShr:  res.value = srcB >> amount;
        srcPkg::OpShra: res.value = $signed(srcB) >>> amount;
        srcPkg::OpShl:  res.value = srcB << amount;
        srcPkg::OpRor: begin
            pair      = {srcB, srcB} >> amount;
            res.value = pair[31:0];
        end
        srcPkg::OpRol: begin
            pair      = {srcB, srcB} << amount;
            res.value = pair[63:32];
        end
        srcPkg::OpAddi: res.value = srcB + imm;
        srcPkg::OpAndi: res.value = srcB & imm;
        srcPkg::OpOri:  res.value = srcB | imm;
        srcPkg::OpNeg:  res.value = ~srcB + 1'b1;
        srcPkg::OpNot:  res.value = ~srcB;
        srcPkg::OpBranch: begin
            res.writes = 1'b0;
            case (word[20:19])  // Low two bits of C2
                2'd0:    res.branchTaken = (tested == '0);
                2'd1:    res.branchTaken = (tested != '0);
                2'd2:    res.branchTaken = tested[31];
                default: res.branchTaken = !tested[31];
            endcase
        end
        default: begin
            res.writes  = 1'b0;  // Unknown or dropped opcode
            res.illegal = 1'b1;
        end
    endcase
    return res;
endfunction

function automatic void updateMirror(input srcPkg::ExecResult res);
    if (res.writes) mirror[res.destReg] = res.value;
endfunction

`endif

// ==== bench/srcCoreTb.sv ====
`default_nettype none

module srcCoreTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int Seed        = 96033;
    localparam int ClockPeriod = 100;
    localparam int ResetCycles = 16;
    localparam int AckLimit    = 12;  // Falling edges before giving up on ack
    localparam int NumImm      = 24;
    localparam int NumRegOps   = 24;  // Each followed by a read back
    localparam int NumBranch   = 18;
    localparam int NumIllegal  = 17;
    localparam int NumTests    = NumImm + 2 * NumRegOps + NumBranch + 2 * NumIllegal + 2;

    logic                            Clock;
    logic                            rstN;
    logic                            req;
    logic [srcPkg::InstrWidth-1:0]   instr;
    logic                            ack;
    logic [srcPkg::InstrWidth-1:0]   result;
    logic [srcPkg::RegAddrWidth-1:0] resultReg;
    logic                            wrote;
    logic                            branchTaken;
    logic                            illegal;

    int                errorCount;
    int                checkCount;
    int                errBase;
    int                chkBase;
    logic              ackSeen;     // Ack at the previous falling edge
    srcPkg::ExecResult expQ [$];    // Predictions awaiting ack
    srcPkg::ExecResult expected;

    `include "srcCoreRef.svh"

    srcCore srcCore_inst (
        .Clock       (Clock),
        .rstN        (rstN),
        .req         (req),
        .instr       (instr),
        .ack         (ack),
        .result      (result),
        .resultReg   (resultReg),
        .wrote       (wrote),
        .branchTaken (branchTaken),
        .illegal     (illegal)
    );

    always #(ClockPeriod / 2) Clock = ~Clock;

    task automatic checkWord(input string name, input logic [srcPkg::InstrWidth-1:0] exp, act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic checkReg(input string name, input logic [srcPkg::RegAddrWidth-1:0] exp, act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic checkFlag(input string name, input logic exp, act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic noteFailure(input string msg);
        errorCount++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    task automatic finishTest(input string name);
        $display("Test %s: %0d checks, %0d errors", name, checkCount - chkBase,
                 errorCount - errBase);
        chkBase = checkCount;
        errBase = errorCount;
    endtask

    function automatic logic [31:0] encodeR(input logic [4:0] op, input logic [3:0] ra, rb, rc);
        return {op, ra, rb, rc, 15'd0};
    endfunction

    function automatic logic [31:0] encodeI(input logic [4:0] op, input logic [3:0] ra, rb,
                                            input logic [18:0] c);
        return {op, ra, rb, c};
    endfunction

    function automatic logic [31:0] encodeBranch(input logic [3:0] ra, c2, input logic [18:0] c);
        return {srcPkg::OpBranch, ra, c2, c};
    endfunction

    // Four-phase transaction, holding req for extra cycles after ack
    task automatic runInstr(input logic [srcPkg::InstrWidth-1:0] word, input int holdCycles);
        srcPkg::ExecResult predicted;
        int                waited;
        predicted = refExecute(word);
        expQ.push_back(predicted);
        updateMirror(predicted);
        @(negedge Clock);
        instr = word;
        req   = 1'b1;
        waited = 0;
        do begin
            @(negedge Clock);
            waited++;
        end while (!ack && waited < AckLimit);
        if (!ack) begin
            noteFailure($sformatf("ack never rose for instruction %h", word));
        end else if (waited != 4) begin  // Capture edge plus three
            noteFailure($sformatf("ack rose %0d cycles after capture, not 3", waited - 1));
        end
        repeat (holdCycles) begin
            @(negedge Clock);
            if (!ack) noteFailure("ack dropped while req was still high");
        end
        req = 1'b0;
        @(negedge Clock);
        if (ack) noteFailure("ack did not fall on the first edge with req low");
        waited = 0;
        while (ack && waited < AckLimit) begin
            @(negedge Clock);
            waited++;
        end
    endtask

    // Compare on the first falling edge that sees ack high
    always @(negedge Clock) begin
        if (rstN && ack && !ackSeen) begin
            if (expQ.size() == 0) begin
                noteFailure("ack rose with no instruction outstanding");
            end else begin
                expected = expQ.pop_front();
                checkWord("result", expected.value, result);
                checkReg("resultReg", expected.destReg, resultReg);
                checkFlag("wrote", expected.writes, wrote);
                checkFlag("branchTaken", expected.branchTaken, branchTaken);
                checkFlag("illegal", expected.illegal, illegal);
            end
        end
        ackSeen = ack;
    end

    initial begin : mainSeq
        logic [4:0]  op;
        logic [3:0]  dst;
        logic [18:0] imm;
        void'($urandom(Seed));
        Clock      = 1'b0;
        rstN       = 1'b0;
        req        = 1'b0;
        instr      = '0;
        errorCount = 0;
        checkCount = 0;
        errBase    = 0;
        chkBase    = 0;
        ackSeen    = 1'b0;
        for (int r = 0; r < srcPkg::RegCount; r++) mirror[r] = '0;
        repeat (ResetCycles) @(posedge Clock);
        @(negedge Clock);
        rstN = 1'b1;
        @(negedge Clock);
        checkFlag("ack", 1'b0, ack);
        checkFlag("wrote", 1'b0, wrote);
        checkFlag("branchTaken", 1'b0, branchTaken);
        checkFlag("illegal", 1'b0, illegal);
        finishTest("reset state");

        for (int r = 0; r < srcPkg::RegCount; r++) begin
            imm     = 19'($urandom());
            imm[18] = r[0];  // Odd registers get a negative C
            runInstr(encodeI(srcPkg::OpAddi, 4'(r), 4'($urandom_range(0, 15)), imm), 0);
        end
        for (int i = 0; i < NumImm - srcPkg::RegCount; i++) begin
            op = i[0] ? srcPkg::OpOri : srcPkg::OpAndi;
            runInstr(encodeI(op, 4'($urandom_range(0, 15)), 4'($urandom_range(0, 15)),
                             19'($urandom())), 0);
        end
        finishTest("immediates");

        for (int i = 0; i < NumRegOps; i++) begin
            // Cycle through all nine R ops, then neg and not
            op  = (i % 11 < 9) ? 5'(srcPkg::OpAdd + i % 11) : 5'(srcPkg::OpNeg + i % 11 - 9);
            dst = 4'($urandom_range(0, 15));
            runInstr(encodeR(op, dst, 4'($urandom_range(0, 15)), 4'($urandom_range(0, 15))), 0);
            runInstr(encodeI(srcPkg::OpAddi, dst + 4'd1, dst, '0), 0);  // Read back
        end
        finishTest("register ops");

        runInstr(encodeI(srcPkg::OpAndi, 4'd1, 4'd1, '0), 0);          // Zero
        runInstr(encodeI(srcPkg::OpAddi, 4'd2, 4'd1, 19'd100), 0);     // Positive
        runInstr(encodeI(srcPkg::OpAddi, 4'd3, 4'd1, 19'h7fffb), 0);   // Minus five
        for (int r = 1; r <= 3; r++) begin
            for (int c = 0; c < 4; c++) begin
                runInstr(encodeBranch(4'(r), {2'($urandom()), 2'(c)}, 19'($urandom())), 0);
            end
        end
        for (int r = 1; r <= 3; r++) begin
            runInstr(encodeI(srcPkg::OpAddi, 4'(r + 3), 4'(r), '0), 0);  // Still unchanged
        end
        finishTest("branch conditions");

        for (int o = 0; o < 32; o++) begin
            if (o inside {[3:14], [17:19]}) continue;
            dst = 4'($urandom_range(0, 15));
            runInstr({5'(o), dst, 23'($urandom())}, 0);
            runInstr(encodeI(srcPkg::OpAddi, dst + 4'd1, dst, '0), 0);
        end
        finishTest("illegal opcodes");

        runInstr(encodeI(srcPkg::OpAddi, 4'd5, 4'd5, 19'd1), 5);  // req held five cycles
        runInstr(encodeI(srcPkg::OpAddi, 4'd6, 4'd5, '0), 0);     // One increment only
        finishTest("request held");

        if (expQ.size() != 0) noteFailure("predicted results left without an ack");
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Twenty periods per transaction, plus reset
    initial begin : watchdog
        #((NumTests * 20 + ResetCycles) * ClockPeriod);
        $display("Watchdog timed out before the test sequence finished");
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/srcCore.sv ====
`default_nettype none

module srcCore (
    input  logic                            Clock,
    input  logic                            rstN,
    input  logic                            req,
    input  logic [srcPkg::InstrWidth-1:0]   instr,
    output logic                            ack,
    output logic [srcPkg::InstrWidth-1:0]   result,
    output logic [srcPkg::RegAddrWidth-1:0] resultReg,
    output logic                            wrote,
    output logic                            branchTaken,
    output logic                            illegal
);

    logic [srcPkg::RegAddrWidth-1:0] rdAddrA, rdAddrB, wrAddr;
    logic [srcPkg::InstrWidth-1:0]   rdDataA, rdDataB, wrData;
    logic                            wrEn;

    stageIf #(.PayloadT(srcPkg::DecodedOp))  decToExe ();
    stageIf #(.PayloadT(srcPkg::ExecResult)) exeToRes ();

    regBank regBank_inst (
        .Clock   (Clock),
        .rstN    (rstN),
        .rdAddrA (rdAddrA),
        .rdAddrB (rdAddrB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .wrEn    (wrEn),
        .wrAddr  (wrAddr),
        .wrData  (wrData)
    );

    instrDecode instrDecode_inst (
        .Clock   (Clock),
        .rstN    (rstN),
        .req     (req),
        .instr   (instr),
        .busy    (ack),  // Ack register doubles as busy
        .rdAddrA (rdAddrA),
        .rdAddrB (rdAddrB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .decOut  (decToExe.source)
    );

    aluExecute aluExecute_inst (
        .Clock  (Clock),
        .rstN   (rstN),
        .decIn  (decToExe.sink),
        .exeOut (exeToRes.source)
    );

    resultStage resultStage_inst (
        .Clock       (Clock),
        .rstN        (rstN),
        .exeIn       (exeToRes.sink),
        .wrEn        (wrEn),
        .wrAddr      (wrAddr),
        .wrData      (wrData),
        .ack         (ack),
        .req         (req),
        .result      (result),
        .resultReg   (resultReg),
        .wrote       (wrote),
        .branchTaken (branchTaken),
        .illegal     (illegal)
    );

endmodule

`default_nettype wire

// ==== hw/resultStage.sv ====
`default_nettype none

module resultStage (
    input  logic                            Clock,
    input  logic                            rstN,
    stageIf.sink                            exeIn,
    output logic                            wrEn,
    output logic [srcPkg::RegAddrWidth-1:0] wrAddr,
    output logic [srcPkg::InstrWidth-1:0]   wrData,
    output logic                            ack,
    input  logic                            req,
    output logic [srcPkg::InstrWidth-1:0]   result,
    output logic [srcPkg::RegAddrWidth-1:0] resultReg,
    output logic                            wrote,
    output logic                            branchTaken,
    output logic                            illegal
);

    srcPkg::ExecResult res;

    assign res = exeIn.payload;

    // Bank write lands on the same edge that raises ack
    assign wrEn   = exeIn.valid && res.writes;
    assign wrAddr = res.destReg;
    assign wrData = res.value;

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            ack         <= 1'b0;
            result      <= '0;
            resultReg   <= '0;
            wrote       <= 1'b0;
            branchTaken <= 1'b0;
            illegal     <= 1'b0;
        end else if (exeIn.valid) begin
            ack         <= 1'b1;
            result      <= res.value;  // Held until next ack
            resultReg   <= res.destReg;
            wrote       <= res.writes;
            branchTaken <= res.branchTaken;
            illegal     <= res.illegal;
        end else if (ack && !req) begin
            ack <= 1'b0;  // Host has dropped req
        end
    end

    // Four-phase order on the host side
    assert property (@(posedge Clock) disable iff (!rstN) $fell(ack) |-> !$past(req));

endmodule

`default_nettype wire

// ==== hw/aluExecute.sv ====
`default_nettype none

module aluExecute (
    input  logic   Clock,
    input  logic   rstN,
    stageIf.sink   decIn,
    stageIf.source exeOut
);

    srcPkg::DecodedOp              dec;
    srcPkg::ExecResult             exeNext;
    logic [4:0]                    shAmt;     // Low five bits of opB
    logic [srcPkg::InstrWidth-1:0] opA, opB;
    logic                          condMet;

    assign dec   = decIn.payload;
    assign opA   = dec.opA;
    assign opB   = dec.opB;
    assign shAmt = opB[4:0];

    // Branch condition on the tested register
    always_comb begin
        case (dec.cond)
            srcPkg::CondZero:    condMet = (opA == '0);
            srcPkg::CondNonzero: condMet = (opA != '0);
            srcPkg::CondMinus:   condMet = opA[srcPkg::InstrWidth-1];
            default:             condMet = !opA[srcPkg::InstrWidth-1];  // Plus
        endcase
    end

    always_comb begin
        exeNext = '0;
        exeNext.destReg = dec.destReg;
        exeNext.illegal = dec.illegal;
        // Branches never write
        exeNext.writes  = dec.writes && (dec.aluOp != srcPkg::AluBranch);
        case (dec.aluOp)
            srcPkg::AluAdd:  exeNext.value = opA + opB;
            srcPkg::AluSub:  exeNext.value = opA - opB;
            srcPkg::AluAnd:  exeNext.value = opA & opB;
            srcPkg::AluOr:   exeNext.value = opA | opB;
            srcPkg::AluShr:  exeNext.value = opA >> shAmt;
            srcPkg::AluShra: exeNext.value = $signed(opA) >>> shAmt;  // Sign fill
            srcPkg::AluShl:  exeNext.value = opA << shAmt;
            srcPkg::AluRor: begin
                // Shift by 32 gives zero, so shAmt of 0 is safe
                exeNext.value = (opA >> shAmt) | (opA << (srcPkg::InstrWidth - shAmt));
            end
            srcPkg::AluRol: begin
                exeNext.value = (opA << shAmt) | (opA >> (srcPkg::InstrWidth - shAmt));
            end
            srcPkg::AluNeg:    exeNext.value = '0 - opA;  // Two's complement
            srcPkg::AluNot:    exeNext.value = ~opA;
            srcPkg::AluBranch: exeNext.branchTaken = condMet;
            default:           exeNext.value = '0;        // Illegal, nothing computed
        endcase
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            exeOut.valid   <= 1'b0;
            exeOut.payload <= '0;
        end else begin
            exeOut.valid <= decIn.valid;
            if (decIn.valid) exeOut.payload <= exeNext;
        end
    end

    // An illegal op from decode must never reach the bank
    assert property (@(posedge Clock) disable iff (!rstN)
        exeOut.valid |-> !(exeOut.payload.writes && exeOut.payload.illegal));

endmodule

`default_nettype wire

// ==== hw/instrDecode.sv ====
`default_nettype none

module instrDecode (
    input  logic                            Clock,
    input  logic                            rstN,
    input  logic                            req,
    input  logic [srcPkg::InstrWidth-1:0]   instr,
    input  logic                            busy,     // Ack still high
    output logic [srcPkg::RegAddrWidth-1:0] rdAddrA,
    output logic [srcPkg::RegAddrWidth-1:0] rdAddrB,
    input  logic [srcPkg::InstrWidth-1:0]   rdDataA,
    input  logic [srcPkg::InstrWidth-1:0]   rdDataB,
    stageIf.source                          decOut
);

    logic [srcPkg::InstrWidth-1:0]   instrReg;
    logic                            pending;  // Captured, ack not yet seen
    logic                            issue;    // Decode strobe, one after capture
    logic                            capture;
    logic [srcPkg::OpcodeWidth-1:0]  opcode;
    logic [srcPkg::RegAddrWidth-1:0] ra, rb, rc, c2;
    logic [srcPkg::ImmWidth-1:0]     c;
    logic [srcPkg::InstrWidth-1:0]   immExt;
    logic                            useImm;
    srcPkg::DecodedOp                decodedNext;

    // New request only when idle
    assign capture = req && !busy && !pending;

    assign opcode = instrReg[31:27];
    assign immExt = {{(srcPkg::InstrWidth - srcPkg::ImmWidth){c[srcPkg::ImmWidth-1]}}, c};

    always_comb begin
        ra = instrReg[26:23];  // Destination, or tested reg for a branch
        rb = '0;
        rc = '0;
        c  = '0;
        c2 = '0;
        useImm = 1'b0;
        decodedNext = '0;
        decodedNext.aluOp = srcPkg::AluNone;
        case (opcode)
            srcPkg::OpAdd, srcPkg::OpSub, srcPkg::OpAnd, srcPkg::OpOr, srcPkg::OpShr,
            srcPkg::OpShra, srcPkg::OpShl, srcPkg::OpRor, srcPkg::OpRol: begin
                rb = instrReg[22:19];
                rc = instrReg[18:15];
                decodedNext.writes = 1'b1;
            end
            srcPkg::OpAddi, srcPkg::OpAndi, srcPkg::OpOri: begin
                rb = instrReg[22:19];
                c  = instrReg[18:0];
                useImm = 1'b1;
                decodedNext.writes = 1'b1;
            end
            srcPkg::OpNeg, srcPkg::OpNot: begin
                rb = instrReg[22:19];  // Single source
                decodedNext.writes = 1'b1;
            end
            srcPkg::OpBranch: begin
                c2 = instrReg[22:19];
            end
            default: decodedNext.illegal = 1'b1;  // Dropped or unused opcode
        endcase
        case (opcode)
            srcPkg::OpAdd, srcPkg::OpAddi: decodedNext.aluOp = srcPkg::AluAdd;
            srcPkg::OpSub:                 decodedNext.aluOp = srcPkg::AluSub;
            srcPkg::OpAnd, srcPkg::OpAndi: decodedNext.aluOp = srcPkg::AluAnd;
            srcPkg::OpOr, srcPkg::OpOri:   decodedNext.aluOp = srcPkg::AluOr;
            srcPkg::OpShr:                 decodedNext.aluOp = srcPkg::AluShr;
            srcPkg::OpShra:                decodedNext.aluOp = srcPkg::AluShra;
            srcPkg::OpShl:                 decodedNext.aluOp = srcPkg::AluShl;
            srcPkg::OpRor:                 decodedNext.aluOp = srcPkg::AluRor;
            srcPkg::OpRol:                 decodedNext.aluOp = srcPkg::AluRol;
            srcPkg::OpNeg:                 decodedNext.aluOp = srcPkg::AluNeg;
            srcPkg::OpNot:                 decodedNext.aluOp = srcPkg::AluNot;
            srcPkg::OpBranch:              decodedNext.aluOp = srcPkg::AluBranch;
            default:                       decodedNext.aluOp = srcPkg::AluNone;
        endcase
        // Operand ports
        rdAddrA = (opcode == srcPkg::OpBranch) ? ra : rb;
        rdAddrB = rc;
        decodedNext.destReg = ra;
        decodedNext.opA     = rdDataA;
        decodedNext.opB     = useImm ? immExt : rdDataB;
        decodedNext.cond    = srcPkg::CondCode'(c2[1:0]);
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            instrReg       <= '0;
            pending        <= 1'b0;
            issue          <= 1'b0;
            decOut.valid   <= 1'b0;
            decOut.payload <= '0;
        end else begin
            issue        <= capture;
            decOut.valid <= issue;  // One-cycle pulse
            if (capture) begin
                instrReg <= instr;
                pending  <= 1'b1;
            end else if (busy) begin
                pending  <= 1'b0;  // Ack seen, next req needs ack low again
            end
            if (issue) decOut.payload <= decodedNext;
        end
    end

    // A decoded op never enters while a previous result is still acknowledged
    assert property (@(posedge Clock) disable iff (!rstN) $rose(decOut.valid) |-> !busy);

endmodule

`default_nettype wire

// ==== hw/regBank.sv ====
`default_nettype none

module regBank (
    input  logic                            Clock,
    input  logic                            rstN,
    input  logic [srcPkg::RegAddrWidth-1:0] rdAddrA,
    input  logic [srcPkg::RegAddrWidth-1:0] rdAddrB,
    output logic [srcPkg::InstrWidth-1:0]   rdDataA,
    output logic [srcPkg::InstrWidth-1:0]   rdDataB,
    input  logic                            wrEn,
    input  logic [srcPkg::RegAddrWidth-1:0] wrAddr,
    input  logic [srcPkg::InstrWidth-1:0]   wrData
);

    logic [srcPkg::InstrWidth-1:0] regs [srcPkg::RegCount];  // R0 is a normal register

    // Asynchronous reads
    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            for (int i = 0; i < srcPkg::RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;  // Single write port
        end
    end

endmodule

`default_nettype wire

// ==== hw/stageIf.sv ====
`default_nettype none

// One-cycle valid pulse with payload, no back-pressure
interface stageIf #(
    parameter type PayloadT = logic
);

    logic    valid;
    PayloadT payload;

    // Producing stage
    modport source (
        output valid,
        output payload
    );

    // Consuming stage
    modport sink (
        input valid,
        input payload
    );

endinterface

`default_nettype wire

// ==== hw/srcPkg.sv ====
`default_nettype none

package srcPkg;

    localparam int InstrWidth   = 32;  // Instruction and data width
    localparam int RegCount     = 16;
    localparam int RegAddrWidth = 4;   // Ra, Rb, Rc field width
    localparam int ImmWidth     = 19;  // C field, sign-extended
    localparam int OpcodeWidth  = 5;

    // R-format group
    localparam logic [OpcodeWidth-1:0] OpAdd  = 5'd3;
    localparam logic [OpcodeWidth-1:0] OpSub  = 5'd4;
    localparam logic [OpcodeWidth-1:0] OpAnd  = 5'd5;
    localparam logic [OpcodeWidth-1:0] OpOr   = 5'd6;
    localparam logic [OpcodeWidth-1:0] OpShr  = 5'd7;
    localparam logic [OpcodeWidth-1:0] OpShra = 5'd8;
    localparam logic [OpcodeWidth-1:0] OpShl  = 5'd9;
    localparam logic [OpcodeWidth-1:0] OpRor  = 5'd10;
    localparam logic [OpcodeWidth-1:0] OpRol  = 5'd11;
    // I-format immediates
    localparam logic [OpcodeWidth-1:0] OpAddi = 5'd12;
    localparam logic [OpcodeWidth-1:0] OpAndi = 5'd13;
    localparam logic [OpcodeWidth-1:0] OpOri  = 5'd14;
    localparam logic [OpcodeWidth-1:0] OpNeg    = 5'd17;  // Unary, Rb source
    localparam logic [OpcodeWidth-1:0] OpNot    = 5'd18;
    localparam logic [OpcodeWidth-1:0] OpBranch = 5'd19;  // Condition in C2

    typedef enum logic [3:0] {
        AluAdd, AluSub, AluAnd, AluOr,
        AluShr, AluShra, AluShl, AluRor, AluRol,
        AluNeg, AluNot,
        AluBranch,  // Condition test only
        AluNone     // Illegal opcode
    } AluOp;

    // Low two bits of C2
    typedef enum logic [1:0] {
        CondZero    = 2'd0,
        CondNonzero = 2'd1,
        CondMinus   = 2'd2,
        CondPlus    = 2'd3
    } CondCode;

    typedef struct packed {
        AluOp                    aluOp;
        logic [RegAddrWidth-1:0] destReg;
        logic [InstrWidth-1:0]   opA;      // Rb, or Ra for a branch
        logic [InstrWidth-1:0]   opB;      // Rc or sign-extended C
        CondCode                 cond;
        logic                    writes;
        logic                    illegal;
    } DecodedOp;

    typedef struct packed {
        logic [InstrWidth-1:0]   value;
        logic [RegAddrWidth-1:0] destReg;
        logic                    writes;
        logic                    branchTaken;
        logic                    illegal;
    } ExecResult;

endpackage

`default_nettype wire
